// File: verification/hist_patterns.txt
# cmd arg1 arg2 [name], numbers in hex
# W addr data | R addr expected name | S code count | D - statusMask
R 04 0 status_after_reset
# coarse pass, bin 0 holds four samples
W 00 9
S 1 2
S 2 2
S 7c 1
S 3ff 1
S 200 1
S 82 1
S 83 1
R 00 1 ctrl_readback
W 00 5
R 04 4 status_after_finish
D 0 2
R 04 2 status_coarse_done
R 08 0 coarse_bin_t1
R 0c 0 winlo_t1
# fine pass over codes 0 to 63, 900 and 400 fall outside
W 00 b
S 1 2
S 2 1
S 9 1
S 384 1
S 190 1
W 00 7
D 0 1
R 04 3 status_fine_done
R 10 2 fine_value_t2
# second run clustered near 700
W 00 9
S 2bc 3
S 2c1 2
S 2b2 1
S 64 1
W 00 5
D 0 2
R 08 a coarse_bin_t3
R 0c 280 winlo_t3
W 00 b
S 2bc 3
S 2c1 1
S 2b2 1
S 281 2
W 00 7
D 0 1
R 10 2be fine_value_t3
# bins 5 and 3 both saturate, lower index wins
W 00 9
S 154 12c
S c8 104
W 00 5
D 0 2
R 08 3 coarse_sat_t4
R 0c c0 winlo_t4
# fine bins 2 and 7 tie at two
W 00 b
S c8 2
S dc 2
S fa 1
W 00 7
D 0 1
R 10 ca fine_tie_t4
# samples offered during clear and scan are held
W 00 9
S 3c 2
S 384 1
W 00 5
S 384 2
D 0 2
R 08 0 bp_first_scan
W 00 5
D 0 2
R 08 e bp_second_scan
R 04 3 status_final

// File: sources.f
+incdir+design
design/histTypesPkg.sv
design/histRegPkg.sv
design/pipeStage.sv
design/binMapper.sv
design/binAccumulator.sv
design/peakScanner.sv
design/histApbRegs.sv
design/histTop.sv
verification/histScoreboard.sv
verification/hist_checker.sv
verification/histTb.sv

// File: verification/histTb.sv
`timescale 1ns/100ps
`include "hist_defs.svh"

module clkGen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

module histTb;

    localparam int AW = `APB_ADDR_WIDTH;
    localparam int DW = `APB_DATA_WIDTH;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_PATTERN = 40;
    localparam logic [31:0] SEED = 32'h92a6e5cb;

    logic                     clk;
    logic                     rstN;
    logic [`SAMPLE_WIDTH-1:0] sampleData;
    logic                     sampleValid;
    logic                     sampleReady;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [AW-1:0]            paddr;
    logic [DW-1:0]            pwdata;
    logic [DW-1:0]            prdata;
    logic                     pready;
    logic                     pslverr;

    string patterns [$];
    int    opCount = 0;
    int    watchdogCycles = 0;
    int    otherErrors = 0;
    int    totalErrors = 0;
    logic  loaded = 1'b0;

    clkGen #(.PERIOD_NS(8.0)) i_clkGen (.clk(clk));

    histTop i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .sampleData  (sampleData),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    histScoreboard i_scoreboard (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pready  (pready),
        .paddr   (paddr),
        .prdata  (prdata)
    );

    // keeps command lines, sums the expected work for the watchdog
    task automatic loadPatterns();
        int          fd;
        string       line;
        string       cmd;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("verification/hist_patterns.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("could not open the pattern file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%s %h %h", cmd, a, b) >= 1 && cmd.getc(0) != "#") begin
                    patterns.push_back(line);
                    // a sample line repeats its code b times
                    opCount += (cmd == "S") ? int'(b) : 1;
                end
            end
            $fclose(fd);
        end
        watchdogCycles = opCount * CYCLES_PER_PATTERN + RESET_CYCLES;
    endtask

    // setup phase, then access until pready
    task automatic apbTransfer(input logic write, input logic [AW-1:0] addr,
                               input logic [DW-1:0] wdata, output logic [DW-1:0] rdata);
        logic done;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        done = 1'b0;
        while (!done) begin
            // mid-cycle, settled since the last edge
            @(negedge clk);
            done = pready;
            rdata = prdata;
            @(posedge clk);
            #1;
        end
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    // random idle gap, then hold until accepted
    task automatic sendSample(input logic [`SAMPLE_WIDTH-1:0] code);
        int   gap;
        logic taken;
        gap = $urandom % 3;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        sampleValid = 1'b1;
        sampleData = code;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = sampleReady;
            @(posedge clk);
            #1;
        end
        sampleValid = 1'b0;
    endtask

    // poll status until every bit of mask is set
    task automatic waitDone(input logic [DW-1:0] mask);
        logic [DW-1:0] rd;
        rd = '0;
        while ((rd & mask) != mask) begin
            i_scoreboard.expectRead(`REG_STATUS, '0, '0, "status_poll");
            apbTransfer(1'b0, `REG_STATUS, '0, rd);
        end
    endtask

    task automatic runPattern(input string line);
        string       cmd;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [DW-1:0] rd;
        name = "";
        void'($sscanf(line, "%s %h %h %s", cmd, a, b, name));
        case (cmd)
            "W": apbTransfer(1'b1, a[AW-1:0], b, rd);
            "R": begin
                i_scoreboard.expectRead(a[AW-1:0], b, '1, name);
                apbTransfer(1'b0, a[AW-1:0], '0, rd);
            end
            "S": begin
                repeat (b) begin
                    sendSample(a[`SAMPLE_WIDTH-1:0]);
                end
            end
            "D": waitDone(b);
            default: begin
                otherErrors++;
                $display("unknown pattern command %s", cmd);
            end
        endcase
    endtask

    initial begin
        void'($urandom(SEED));
        rstN = 1'b0;
        sampleData = '0;
        sampleValid = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        loadPatterns();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;
        foreach (patterns[i]) begin
            runPattern(patterns[i]);
        end
        repeat (4) @(posedge clk);
        // leftover expectations mean a read never happened
        otherErrors += i_scoreboard.unexpected + i_scoreboard.pendingCount();
        otherErrors += i_dut.i_checker.failCount;
        totalErrors = i_scoreboard.mismatches + otherErrors;
        $display("%0d checks, %0d mismatches, %0d other errors",
                 i_scoreboard.checks, i_scoreboard.mismatches, otherErrors);
        if (totalErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // limit scales with the expanded pattern count
    initial begin
        wait (loaded);
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles before the patterns completed",
                 watchdogCycles);
        $display("Test failed");
        $finish;
    end

endmodule

// File: verification/hist_checker.sv
`timescale 1ns/100ps
`include "hist_defs.svh"

module histChecker (
    input logic                     clk,
    input logic                     rstN,
    input logic                     sampleValid,
    input logic [`SAMPLE_WIDTH-1:0] sampleData,
    input logic                     sampleReady,
    input logic                     pslverr,
    input logic                     clearStart,
    input logic                     finishStart
);

    // number of failed assertions
    int failCount = 0;

    // a stalled sample stays offered with the same code
    sampleHeld: assert property (@(posedge clk) disable iff (!rstN)
        sampleValid && !sampleReady |=> sampleValid && $stable(sampleData))
        else begin
            failCount++;
            $error("sample withdrawn or changed before it was accepted");
        end

    // register block never signals an error
    noSlvErr: assert property (@(posedge clk) disable iff (!rstN) !pslverr)
        else begin
            failCount++;
            $error("pslverr went high");
        end

    // clear sweep lasts BIN_COUNT cycles
    // a scan runs at least that long
    // input stays closed for all of it
    readyWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        (clearStart || finishStart) |=> (!sampleReady) [*`BIN_COUNT])
        else begin
            failCount++;
            $error("sampleReady rose too early after a clear or finish strobe");
        end

endmodule

bind histTop histChecker i_checker (
    .clk         (clk),
    .rstN        (rstN),
    .sampleValid (sampleValid),
    .sampleData  (sampleData),
    .sampleReady (sampleReady),
    .pslverr     (pslverr),
    .clearStart  (ctrl.clear),
    .finishStart (ctrl.finish)
);

// File: verification/histScoreboard.sv
`timescale 1ns/100ps
`include "hist_defs.svh"

module histScoreboard (
    input logic                       clk,
    input logic                       rstN,
    input logic                       psel,
    input logic                       penable,
    input logic                       pwrite,
    input logic                       pready,
    input logic [`APB_ADDR_WIDTH-1:0] paddr,
    input logic [`APB_DATA_WIDTH-1:0] prdata
);

    // expected reads, in issue order
    logic [`APB_ADDR_WIDTH-1:0] expAddr [$];
    logic [`APB_DATA_WIDTH-1:0] expData [$];
    logic [`APB_DATA_WIDTH-1:0] expMask [$];
    string                      expName [$];

    logic [`APB_ADDR_WIDTH-1:0] wantAddr;
    logic [`APB_DATA_WIDTH-1:0] wantData;
    logic [`APB_DATA_WIDTH-1:0] wantMask;
    string                      wantName;

    int checks = 0;
    int mismatches = 0;
    int unexpected = 0;

    // queued by the testbench before the read starts
    // zero mask for status polls
    task automatic expectRead(input logic [`APB_ADDR_WIDTH-1:0] addr,
                              input logic [`APB_DATA_WIDTH-1:0] data,
                              input logic [`APB_DATA_WIDTH-1:0] mask,
                              input string name);
        expAddr.push_back(addr);
        expData.push_back(data);
        expMask.push_back(mask);
        expName.push_back(name);
    endtask

    function automatic int pendingCount();
        return expAddr.size();
    endfunction

    // completed read = access phase with pready
    always @(posedge clk) begin
        if (rstN && psel && penable && !pwrite && pready) begin
            if (expAddr.size() == 0) begin
                unexpected++;
                $display("read of address 0x%0h arrived with no expected value queued", paddr);
            end else begin
                wantAddr = expAddr.pop_front();
                wantData = expData.pop_front();
                wantMask = expMask.pop_front();
                wantName = expName.pop_front();
                if (wantAddr != paddr) begin
                    unexpected++;
                    $display("read went to address 0x%0h but 0x%0h was expected (%s)",
                             paddr, wantAddr, wantName);
                end else if (wantMask != '0) begin
                    checks++;
                    if ((prdata & wantMask) != (wantData & wantMask)) begin
                        mismatches++;
                        $display("ERR %s expected 0x%0h actual 0x%0h",
                                 wantName, wantData, prdata);
                    end
                end
            end
        end
    end

endmodule

// File: design/histTop.sv
`timescale 1ns/100ps
`include "hist_defs.svh"

module histTop (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`SAMPLE_WIDTH-1:0]   sampleData,
    input  logic                       sampleValid,
    output logic                       sampleReady,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`APB_DATA_WIDTH-1:0] pwdata,
    output logic [`APB_DATA_WIDTH-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr
);

    histRegPkg::ctrlT            ctrl;
    histRegPkg::peakT            peak;
    histTypesPkg::sampleT        inSample;
    histTypesPkg::sampleT        stageSample;
    histTypesPkg::binReqT        mapReq;
    histTypesPkg::binReqT        accReq;
    histTypesPkg::codeT          winLo;
    logic                        inStageReady;
    logic                        stageValid;
    logic                        mapperReady;
    logic                        mapValid;
    logic                        reqStageReady;
    logic                        accValid;
    logic                        accReady;
    logic [`BIN_WIDTH-1:0]       scanAddr;
    logic [`COUNT_WIDTH-1:0]     scanCount;
    logic                        clearBusy;
    logic                        accIdle;
    logic                        scanBusy;
    logic                        scanDone;

    // pass tag taken at acceptance
    assign inSample.value = sampleData;
    assign inSample.pass = ctrl.pass;
    // enable gates both sides of the handshake
    assign sampleReady = inStageReady && ctrl.enable;

    // input slice
    pipeStage #(
        .payloadT(histTypesPkg::sampleT)
    ) i_inStage (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (sampleValid && ctrl.enable),
        .inData   (inSample),
        .outReady (mapperReady),
        .inReady  (inStageReady),
        .outValid (stageValid),
        .outData  (stageSample)
    );

    binMapper i_mapper (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (stageValid),
        .inData   (stageSample),
        .winLo    (winLo),
        .outReady (reqStageReady),
        .inReady  (mapperReady),
        .outValid (mapValid),
        .outData  (mapReq)
    );

    // request slice ahead of the memory
    pipeStage #(
        .payloadT(histTypesPkg::binReqT)
    ) i_reqStage (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (mapValid),
        .inData   (mapReq),
        .outReady (accReady),
        .inReady  (reqStageReady),
        .outValid (accValid),
        .outData  (accReq)
    );

    binAccumulator i_acc (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (accValid),
        .inData     (accReq),
        .clearStart (ctrl.clear),
        .scanAddr   (scanAddr),
        .inReady    (accReady),
        .scanCount  (scanCount),
        .clearBusy  (clearBusy),
        .idle       (accIdle)
    );

    peakScanner i_scanner (
        .clk         (clk),
        .rstN        (rstN),
        .finishStart (ctrl.finish),
        .pass        (ctrl.pass),
        .scanCount   (scanCount),
        .idle        (accIdle),
        .scanAddr    (scanAddr),
        .scanBusy    (scanBusy),
        .peak        (peak),
        .winLo       (winLo),
        .scanDone    (scanDone)
    );

    histApbRegs i_regs (
        .clk       (clk),
        .rstN      (rstN),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .peak      (peak),
        .scanDone  (scanDone),
        .scanBusy  (scanBusy),
        .clearBusy (clearBusy),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .ctrl      (ctrl)
    );

endmodule

// File: design/histApbRegs.sv
`timescale 1ns/100ps
`include "hist_defs.svh"

module histApbRegs (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`APB_DATA_WIDTH-1:0] pwdata,
    input  histRegPkg::peakT           peak,
    input  logic                       scanDone,
    input  logic                       scanBusy,
    input  logic                       clearBusy,
    output logic [`APB_DATA_WIDTH-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output histRegPkg::ctrlT           ctrl
);

    localparam int DW = `APB_DATA_WIDTH;
    localparam int CW = $bits(histRegPkg::ctrlT);

    logic               enableReg;
    histTypesPkg::passT passReg;
    logic               clearStb;
    logic               finishStb;
    logic               coarseDone;
    logic               fineDone;
    logic               busy;
    logic               ctrlWrite;
    histRegPkg::ctrlT   wrCtrl;
    histRegPkg::ctrlT   rdCtrl;
    histRegPkg::statusT status;

    // zero wait states, never an error
    assign pready = 1'b1;
    assign pslverr = 1'b0;

    // write lands in the access phase
    assign ctrlWrite = psel && penable && pwrite && (paddr == `REG_CTRL);
    assign wrCtrl = histRegPkg::ctrlT'(pwdata[CW-1:0]);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            enableReg <= 1'b0;
            passReg <= histTypesPkg::passCoarse;
            clearStb <= 1'b0;
            finishStb <= 1'b0;
        end else begin
            // strobes last one cycle
            clearStb <= ctrlWrite && wrCtrl.clear;
            finishStb <= ctrlWrite && wrCtrl.finish;
            if (ctrlWrite) begin
                enableReg <= wrCtrl.enable;
                passReg <= wrCtrl.pass;
            end
        end
    end

    // done bits per pass
    // finish write clears the one it targets
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            coarseDone <= 1'b0;
            fineDone <= 1'b0;
        end else if (ctrlWrite && wrCtrl.finish) begin
            if (wrCtrl.pass == histTypesPkg::passCoarse) begin
                coarseDone <= 1'b0;
            end else begin
                fineDone <= 1'b0;
            end
        end else if (scanDone) begin
            if (passReg == histTypesPkg::passCoarse) begin
                coarseDone <= 1'b1;
            end else begin
                fineDone <= 1'b1;
            end
        end
    end

    // strobe cycles count as busy too
    assign busy = clearStb || finishStb || scanBusy || clearBusy;

    // samples are held off while busy
    assign ctrl.clear = clearStb;
    assign ctrl.finish = finishStb;
    assign ctrl.pass = passReg;
    assign ctrl.enable = enableReg && !busy;

    // read views
    assign rdCtrl.clear = 1'b0;
    assign rdCtrl.finish = 1'b0;
    assign rdCtrl.pass = passReg;
    assign rdCtrl.enable = enableReg;
    assign status.busy = busy;
    assign status.coarseDone = coarseDone;
    assign status.fineDone = fineDone;

    // read mux, decoded from paddr alone
    always_comb begin
        case (paddr)
            `REG_CTRL:   prdata = DW'(rdCtrl);
            `REG_STATUS: prdata = DW'(status);
            `REG_COARSE: prdata = DW'(peak.coarseBin);
            `REG_WINLO:  prdata = DW'(peak.winLo);
            `REG_FINE:   prdata = DW'(peak.fineValue);
            default:     prdata = '0;
        endcase
    end

endmodule

// File: design/peakScanner.sv
`timescale 1ns/100ps
`include "hist_defs.svh"

module peakScanner (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    finishStart,
    input  histTypesPkg::passT      pass,
    input  logic [`COUNT_WIDTH-1:0] scanCount,
    input  logic                    idle,
    output logic [`BIN_WIDTH-1:0]   scanAddr,
    output logic                    scanBusy,
    output histRegPkg::peakT        peak,
    output histTypesPkg::codeT      winLo,
    output logic                    scanDone
);

    localparam int BW = `BIN_WIDTH;
    localparam logic [BW-1:0] LAST_BIN = BW'(`BIN_COUNT - 1);
    // enough cycles for the last accepted sample to reach the memory
    localparam logic [1:0] DRAIN_CYCLES = 2'd2;
    // half a fine bin
    localparam histTypesPkg::codeT CENTRE = histTypesPkg::codeT'((1 << `FINE_SHIFT) >> 1);

    typedef enum logic [2:0] {
        sIdle,
        sWait,
        sScan,
        sFinal,
        sDone
    } stateT;

    stateT                   state;
    logic [1:0]              drainCnt;
    histTypesPkg::passT      scanPass;
    logic [`COUNT_WIDTH-1:0] bestCount;
    logic [BW-1:0]           bestBin;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
            drainCnt <= '0;
            scanPass <= histTypesPkg::passCoarse;
            scanAddr <= '0;
            bestCount <= '0;
            bestBin <= '0;
            peak <= '0;
        end else begin
            case (state)
                sIdle: begin
                    // pass is latched so a later ctrl write can't change it
                    if (finishStart) begin
                        state <= sWait;
                        drainCnt <= DRAIN_CYCLES;
                        scanPass <= pass;
                    end
                end
                sWait: begin
                    // input is gated, let in-flight samples land
                    if (drainCnt != '0) begin
                        drainCnt <= drainCnt - 1'b1;
                    end else if (idle) begin
                        state <= sScan;
                        scanAddr <= '0;
                    end
                end
                sScan: begin
                    // strict compare keeps the lowest bin on ties
                    if (scanAddr == '0 || scanCount > bestCount) begin
                        bestCount <= scanCount;
                        bestBin <= scanAddr;
                    end
                    if (scanAddr == LAST_BIN) begin
                        state <= sFinal;
                    end else begin
                        scanAddr <= scanAddr + 1'b1;
                    end
                end
                sFinal: begin
                    if (scanPass == histTypesPkg::passCoarse) begin
                        // window starts at the coarse bin base
                        peak.coarseBin <= bestBin;
                        peak.winLo <= histTypesPkg::codeT'(bestBin) << `WIN_SHIFT;
                    end else begin
                        // centre code of the fine bin
                        peak.fineValue <= peak.winLo
                                        + (histTypesPkg::codeT'(bestBin) << `FINE_SHIFT)
                                        + CENTRE;
                    end
                    state <= sDone;
                end
                sDone: begin
                    state <= sIdle;
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    assign scanBusy = (state != sIdle);
    // one-cycle pulse, results already stored
    assign scanDone = (state == sDone);
    // window start for the fine mapper
    assign winLo = peak.winLo;

endmodule

// File: design/binAccumulator.sv
`timescale 1ns/100ps
`include "hist_defs.svh"

module binAccumulator (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     inValid,
    input  histTypesPkg::binReqT     inData,
    input  logic                     clearStart,
    input  logic [`BIN_WIDTH-1:0]    scanAddr,
    output logic                     inReady,
    output logic [`COUNT_WIDTH-1:0]  scanCount,
    output logic                     clearBusy,
    output logic                     idle
);

    localparam int BW = `BIN_WIDTH;
    localparam logic [BW-1:0] LAST_BIN = BW'(`BIN_COUNT - 1);

    // count memory
    logic [`COUNT_WIDTH-1:0] counts [`BIN_COUNT];
    logic [BW-1:0]           clearAddr;
    logic                    accept;
    logic                    atMax;

    // no requests taken while the sweep runs
    assign inReady = !clearBusy;
    assign accept = inValid && inReady;
    // saturation check on the addressed bin
    assign atMax = &counts[inData.bin];

    // clear sweep, one address per cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            clearBusy <= 1'b0;
            clearAddr <= '0;
        end else if (clearStart) begin
            clearBusy <= 1'b1;
            clearAddr <= '0;
        end else if (clearBusy) begin
            clearAddr <= clearAddr + 1'b1;
            if (clearAddr == LAST_BIN) begin
                clearBusy <= 1'b0;
            end
        end
    end

    // read-modify-write in one cycle
    // sweep wins over any request
    always_ff @(posedge clk) begin
        if (clearBusy) begin
            counts[clearAddr] <= '0;
        end else if (accept && !atMax) begin
            counts[inData.bin] <= counts[inData.bin] + 1'b1;
        end
    end

    // scanner read port, combinational
    assign scanCount = counts[scanAddr];

    // nothing waiting to be written
    assign idle = !inValid && !clearBusy;

endmodule

// File: design/binMapper.sv
`timescale 1ns/100ps
`include "hist_defs.svh"

module binMapper (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  histTypesPkg::sampleT inData,
    input  histTypesPkg::codeT   winLo,
    input  logic                 outReady,
    output logic                 inReady,
    output logic                 outValid,
    output histTypesPkg::binReqT outData
);

    localparam int SW = `SAMPLE_WIDTH;
    localparam int BW = `BIN_WIDTH;
    // fine window covers one coarse bin
    localparam histTypesPkg::codeT WINDOW_SPAN = histTypesPkg::codeT'(1 << `WIN_SHIFT);

    histTypesPkg::codeT offset;
    logic               inWindow;
    logic               keep;
    logic [BW-1:0]      binIdx;

    // distance from window start, wraps when below it
    assign offset = inData.value - winLo;
    assign inWindow = (inData.value >= winLo) && (offset < WINDOW_SPAN);

    always_comb begin
        if (inData.pass == histTypesPkg::passCoarse) begin
            // coarse bin from the top bits
            binIdx = inData.value[SW-1 -: BW];
            keep = 1'b1;
        end else begin
            // fine bin, 4 codes each
            binIdx = offset[`FINE_SHIFT +: BW];
            keep = inWindow;
        end
    end

    // registered output slice
    assign inReady = !outValid || outReady;

    // out-of-window samples are consumed and leave a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid && keep;
        end
    end

    always_ff @(posedge clk) begin
        if (inReady && inValid) begin
            outData.bin <= binIdx;
        end
    end

endmodule

// File: design/pipeStage.sv
`timescale 1ns/100ps

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  payloadT inData,
    input  logic    outReady,
    output logic    inReady,
    output logic    outValid,
    output payloadT outData
);

    // takes a new entry when empty or draining this cycle
    assign inReady = !outValid || outReady;

    // occupancy flag
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    // payload only moves on a transfer
    // held while the consumer stalls
    always_ff @(posedge clk) begin
        if (inReady && inValid) begin
            outData <= inData;
        end
    end

endmodule

// File: design/histRegPkg.sv
`include "hist_defs.svh"

package histRegPkg;

    // control word, bit 0 is enable
    // clear and finish are single-cycle strobes
    typedef struct packed {
        logic               clear;
        logic               finish;
        histTypesPkg::passT pass;
        logic               enable;
    } ctrlT;

    // status word, bit 0 is fineDone
    typedef struct packed {
        logic busy;
        logic coarseDone;
        logic fineDone;
    } statusT;

    // scan results
    // winLo is the first code of the fine window
    // fineValue is the centre code of the fine peak bin
    typedef struct packed {
        logic [`BIN_WIDTH-1:0]    coarseBin;
        logic [`SAMPLE_WIDTH-1:0] winLo;
        logic [`SAMPLE_WIDTH-1:0] fineValue;
    } peakT;

endpackage

// File: design/histTypesPkg.sv
`include "hist_defs.svh"

package histTypesPkg;

    // which histogram a sample belongs to
    typedef enum logic {
        passCoarse = 1'b0,
        passFine   = 1'b1
    } passT;

    // one sample code
    typedef logic [`SAMPLE_WIDTH-1:0] codeT;

    // sample as it enters the pipeline
    // tagged with the pass active at acceptance
    typedef struct packed {
        codeT value;
        passT pass;
    } sampleT;

    // mapped request toward the count memory
    typedef struct packed {
        logic [`BIN_WIDTH-1:0] bin;
    } binReqT;

endpackage

// File: design/hist_defs.svh
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// raw sample code width
`define SAMPLE_WIDTH 10
// bins per histogram and the index width
`define BIN_COUNT 16
`define BIN_WIDTH 4
// per-bin counter, saturates at all ones
`define COUNT_WIDTH 8
// log2 of codes per fine bin
`define FINE_SHIFT 2
// log2 of codes per coarse bin, also the fine window span
`define WIN_SHIFT 6

// apb bus widths
`define APB_ADDR_WIDTH 8
`define APB_DATA_WIDTH 32

// register map
`define REG_CTRL 8'h00
`define REG_STATUS 8'h04
`define REG_COARSE 8'h08
`define REG_WINLO 8'h0C
`define REG_FINE 8'h10

`endif
